/* list.f */
src/isa_pkg.sv
src/ctrl_pkg.sv
src/opcode_decoder.sv
src/seq_fsm.sv
src/ctrl_encoder.sv
src/popcorn_sequencer.sv
sim/tb_sequencer.sv

/* run_sim.sh */
#!/bin/sh
# build and run the sequencer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_sequencer -f list.f
./obj_dir/Vtb_sequencer > sim.log 2>&1 || true
cat sim.log

if grep -qx "TB PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

/* sim/seq_patterns.hex */
// columns: opcode, flags {carry,positive,zero}, expected seq_state, expected ctrl word
// ctrl in any row is the word decided in the row before it
11 0 01 fff80 // alu reg ax, reset word
11 0 02 1ffc6 // fetch
42 0 01 fb991 // cmp reg bx, alu word shown
42 0 02 1ffc6
8d 0 01 ff98a // ld reg p
8d 0 02 1ffc6
91 0 01 fbdc5 // st ax
91 0 02 1ffc6
94 0 01 fddc9 // st flag
94 0 02 1ffc6
50 0 01 ff949 // push encoding as nop, st flag word with flag_mux low
50 0 02 1ffc6
1f 0 01 ffdc6 // alu imm
1f 0 02 1ffc6
1f 0 04 ffdc6
47 0 01 2b99e // cmp imm
47 0 02 1ffc6
47 0 04 ffdc6
87 0 01 2f98e // ldi acc
87 0 02 1ffc6
87 0 04 ffdc6
af 0 01 2bdc6 // ldi p
af 0 02 1ffc6
af 0 04 ffdc6
98 1 01 2f5c6 // je, zero set
98 1 02 1ffc6
98 1 04 ffdc6
98 1 08 2fdc6
98 6 01 f7cc6 // je, zero clear
98 6 02 1ffc6
98 6 04 ffdc6
98 6 08 2fdc6
a0 1 01 f7dc6 // jne, zero set
a0 1 02 1ffc6
a0 1 04 ffdc6
a0 1 08 2fdc6
a0 6 01 f7dc6 // jne, zero clear
a0 6 02 1ffc6
a0 6 04 ffdc6
a0 6 08 2fdc6
a8 2 01 f7cc6 // jp, positive set
a8 2 02 1ffc6
a8 2 04 ffdc6
a8 2 08 2fdc6
a8 5 01 f7cc6 // jp, positive clear
a8 5 02 1ffc6
a8 5 04 ffdc6
a8 5 08 2fdc6
b0 2 01 f7dc6 // jn, positive set
b0 2 02 1ffc6
b0 2 04 ffdc6
b0 2 08 2fdc6
b0 5 01 f7dc6 // jn, positive clear
b0 5 02 1ffc6
b0 5 04 ffdc6
b0 5 08 2fdc6
b8 4 01 f7cc6 // jc, carry set
b8 4 02 1ffc6
b8 4 04 ffdc6
b8 4 08 2fdc6
b8 3 01 f7cc6 // jc, carry clear
b8 3 02 1ffc6
b8 3 04 ffdc6
b8 3 08 2fdc6
c0 4 01 f7dc6 // jnc, carry set
c0 4 02 1ffc6
c0 4 04 ffdc6
c0 4 08 2fdc6
c0 3 01 f7dc6 // jnc, carry clear
c0 3 02 1ffc6
c0 3 04 ffdc6
c0 3 08 2fdc6
c8 0 01 f7cc6 // jmp
c8 0 02 1ffc6
c8 0 04 ffdc6
c8 0 08 2fdc6
d0 7 01 f7cc6 // undefined condition, all flags set
d0 7 02 1ffc6
d0 7 04 ffdc6
d0 7 08 2fdc6
00 0 01 f7dc6 // last branch word, not taken

/* sim/tb_sequencer.sv */
/* tb_sequencer
   streams per-cycle opcode and flag stimulus into the sequencer and checks
   the step state and control word of every cycle against the pattern file */
module tb_sequencer
	import isa_pkg::*;
	import ctrl_pkg::*;
();

	localparam int clk_period = 40;
	localparam int max_rows   = 128;	// pattern memory depth in cycles
	localparam int row_words  = 4;	// opcode, flags, state, ctrl

	logic       sys_clk;
	logic       sys_rst;
	opcode_u    reg_opl;
	flag_t      reg_flag;
	seq_state_t seq_state;
	ctrl_word_t ctrl;

	logic [19:0] pat_mem [0:max_rows*row_words-1];	// one word per field
	int          n_rows;	// cycles found in the file
	logic        loaded;	// starts the watchdog

	popcorn_sequencer #(.op_width(8)) dut_i (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.reg_opl   (reg_opl),
		.reg_flag  (reg_flag),
		.seq_state (seq_state),
		.ctrl      (ctrl)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(clk_period/2) sys_clk = ~sys_clk;
	end

	task automatic check_state(input seq_state_t exp, input seq_state_t act, input string what);
		if (act !== exp) begin
			$display("Fail at %0t: %s seq_state expected %h got %h", $time, what, exp, act);
			$display("TB FAILED");
			$fatal(1, "seq_state mismatch");
		end
	endtask

	task automatic check_ctrl(input ctrl_word_t exp, input ctrl_word_t act, input string what);
		if (act !== exp) begin
			$display("Fail at %0t: %s ctrl expected %h got %h", $time, what, exp, act);
			$display("TB FAILED");
			$fatal(1, "control word mismatch");
		end
	endtask

	// fills with address-tagged words above any opcode, then counts rows
	task automatic load_patterns();
		int a;
		for (a = 0; a < max_rows*row_words; a++)
			pat_mem[a] = {8'hf0, 12'(a)};	// marks slots the file leaves empty
		$readmemh("sim/seq_patterns.hex", pat_mem);
		n_rows = 0;
		while (n_rows < max_rows && pat_mem[n_rows*row_words] < 20'h100)
			n_rows++;
		if (n_rows == 0) begin
			$display("no stimulus rows could be read from sim/seq_patterns.hex");
			$display("TB FAILED");
			$fatal(1, "empty pattern file");
		end
		for (a = 0; a < n_rows; a++) begin
			if (pat_mem[a*row_words+1] > 20'h7 || pat_mem[a*row_words+2] > 20'h3f) begin
				$display("pattern row %0d has a flag or state field out of range", a);
				$display("TB FAILED");
				$fatal(1, "malformed pattern file");
			end
		end
	endtask

	task automatic apply_row(input int row);
		reg_opl  = opcode_u'(pat_mem[row*row_words][7:0]);
		reg_flag = flag_t'(pat_mem[row*row_words+1][2:0]);
	endtask

	task automatic check_row(input int row);
		seq_state_t exp_state;
		ctrl_word_t exp_ctrl;
		exp_state = seq_state_t'(pat_mem[row*row_words+2][5:0]);
		exp_ctrl  = ctrl_word_t'(pat_mem[row*row_words+3]);
		check_state(exp_state, seq_state, $sformatf("row %0d", row));
		check_ctrl(exp_ctrl, ctrl, $sformatf("row %0d", row));
	endtask

	initial begin
		sys_rst  = 1'b0;	// held low from time zero
		reg_opl  = '0;
		reg_flag = '0;
		loaded   = 1'b0;
		n_rows   = 0;
		load_patterns();
		loaded = 1'b1;
		repeat (3) @(posedge sys_clk);
		#2;
		check_row(0);	// row 0 holds the reset word
		sys_rst = 1'b1;
		for (int i = 0; i < n_rows; i++) begin
			apply_row(i);	// 2 units after the edge
			#(clk_period - 4);	// just before the next edge
			check_row(i);
			@(posedge sys_clk);
			#2;
		end
		$display("TB PASSED");
		$finish;
	end

	// limit scales with the pattern count
	initial begin
		wait (loaded);
		#(n_rows * clk_period * 2 + 400);
		$display("timeout: the pattern stream did not finish in %0d time units",
			n_rows * clk_period * 2 + 400);
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

/* src/ctrl_encoder.sv */
/* ctrl_encoder
   builds the control word for the current step and instruction class,
   registered so it takes effect in the following step */
module ctrl_encoder
	import isa_pkg::*;
	import ctrl_pkg::*;
#(
	parameter int op_width = 8
) (
	input  logic       sys_clk,
	input  logic       sys_rst,
	input  seq_state_t seq_state,
	input  decoded_t   decoded,
	output ctrl_word_t ctrl
);

	localparam int sel_w = op_width - 5;	// register field below the 5 class bits

	ctrl_word_t        ctrl_nxt;
	logic [sel_w-1:0]  st_dst;	// st target, from src field
	logic [sel_w-1:0]  ldi_dst;	// ldi target, bits 5:3
	logic              imm_cls;	// needs an operand fetch in s2

	assign st_dst  = decoded.src_sel;
	assign ldi_dst = decoded.dest_sel;
	assign imm_cls = (decoded.iclass == alu_imm) || (decoded.iclass == cmp_imm) ||
		(decoded.iclass == ldi) || (decoded.iclass == branch);

	always_comb begin
		ctrl_nxt = ctrl_idle;
		case (seq_state)
			s0: begin
				ctrl_nxt.code_cs_l = 1'b0;	// read opcode
				ctrl_nxt.code_rd_l = 1'b0;
				ctrl_nxt.w_opl_l   = 1'b0;
			end
			s1: begin
				ctrl_nxt.w_pc_l = 1'b0;	// pc steps for every class
				case (decoded.iclass)
					alu_reg: begin
						ctrl_nxt.alu_func = decoded.alu_op;
						ctrl_nxt.w_acc_l  = 1'b0;
						ctrl_nxt.w_flag_l = 1'b0;
						ctrl_nxt.bbus_mux = decoded.src_sel;
					end
					cmp_reg: begin
						ctrl_nxt.alu_func = alu_sub;	// flags only
						ctrl_nxt.w_flag_l = 1'b0;
						ctrl_nxt.bbus_mux = decoded.src_sel;
					end
					ld_reg: begin
						ctrl_nxt.alu_func = alu_pass_b;
						ctrl_nxt.w_acc_l  = 1'b0;
						ctrl_nxt.bbus_mux = decoded.src_sel;
					end
					st_reg: begin
						ctrl_nxt.alu_func = alu_pass_a;	// acc onto c_bus
						ctrl_nxt.bbus_mux = sel_ax;	// keeps port off b_bus
						case (st_dst)
							sel_ax: ctrl_nxt.w_ax_l = 1'b0;
							sel_bx: ctrl_nxt.w_bx_l = 1'b0;
							sel_flag: begin
								ctrl_nxt.w_flag_l = 1'b0;
								ctrl_nxt.flag_mux = 1'b0;	// flags from c_bus
							end
							sel_p:   ctrl_nxt.w_p_l = 1'b0;
							default: ;	// no writable target
						endcase
					end
					default: ;	// imm, branch, nop: pc only
				endcase
			end
			s2: begin
				if (imm_cls) begin
					ctrl_nxt.code_cs_l = 1'b0;	// fetch operand byte
					ctrl_nxt.code_rd_l = 1'b0;
					ctrl_nxt.w_oplo_l  = 1'b0;
					ctrl_nxt.w_pc_l    = 1'b0;
				end
				case (decoded.iclass)
					ldi: begin
						case (ldi_dst)
							sel_acc: ctrl_nxt.w_acc_l = 1'b0;
							sel_ax:  ctrl_nxt.w_ax_l  = 1'b0;
							sel_bx:  ctrl_nxt.w_bx_l  = 1'b0;
							sel_p:   ctrl_nxt.w_p_l   = 1'b0;
							default: ;
						endcase
					end
					alu_imm: begin
						ctrl_nxt.alu_func = decoded.alu_op;
						ctrl_nxt.w_acc_l  = 1'b0;
						ctrl_nxt.w_flag_l = 1'b0;
					end
					cmp_imm: begin
						ctrl_nxt.alu_func = alu_sub;
						ctrl_nxt.w_flag_l = 1'b0;
					end
					default: ;	// branch needs only the common fetch
				endcase
			end
			s3: begin
				if (decoded.iclass == branch) begin
					ctrl_nxt.w_ophi_l = 1'b0;	// high target byte
					ctrl_nxt.w_pc_l   = 1'b0;
					ctrl_nxt.pc_mux   = ~decoded.taken;	// low loads target
				end
			end
			default: ;	// reserved steps stay idle
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst) begin
		if (!sys_rst)
			ctrl <= ctrl_reset;
		else
			ctrl <= ctrl_nxt;
	end

endmodule

/* src/ctrl_pkg.sv */
/* ctrl_pkg
   datapath control side: sequencer states and the registered control word */
package ctrl_pkg;
	import isa_pkg::*;

	typedef enum logic [5:0] {
		s0 = 6'b000001,	// opcode fetch
		s1 = 6'b000010,	// register-direct execute
		s2 = 6'b000100,	// immediate operand
		s3 = 6'b001000,	// branch high operand
		s4 = 6'b010000,	// reserved
		s5 = 6'b100000	// reserved
	} seq_state_t;

	typedef struct packed {
		logic     code_cs_l;	// code memory select
		logic     code_rd_l;	// code memory read
		logic     w_opl_l;	// opcode latch
		logic     w_oplo_l;	// operand low latch
		logic     w_ophi_l;	// operand high latch
		logic     w_acc_l;
		logic     w_ax_l;
		logic     w_bx_l;
		logic     w_p_l;
		logic     w_flag_l;
		logic     w_pc_l;
		logic     pc_mux;	// low loads branch target
		logic     flag_mux;	// low takes flags from c_bus
		alu_op_t  alu_func;
		reg_sel_t bbus_mux;
	} ctrl_word_t;

	localparam ctrl_word_t ctrl_reset = '{
		code_cs_l: 1'b1, code_rd_l: 1'b1, w_opl_l: 1'b1,
		w_oplo_l: 1'b1, w_ophi_l: 1'b1, w_acc_l: 1'b1,
		w_ax_l: 1'b1, w_bx_l: 1'b1, w_p_l: 1'b1,
		w_flag_l: 1'b1, w_pc_l: 1'b1,
		pc_mux: 1'b1, flag_mux: 1'b1,
		alu_func: alu_nul, bbus_mux: sel_acc
	};

	// base word for every step, strobes all idle
	localparam ctrl_word_t ctrl_idle = '{
		code_cs_l: 1'b1, code_rd_l: 1'b1, w_opl_l: 1'b1,
		w_oplo_l: 1'b1, w_ophi_l: 1'b1, w_acc_l: 1'b1,
		w_ax_l: 1'b1, w_bx_l: 1'b1, w_p_l: 1'b1,
		w_flag_l: 1'b1, w_pc_l: 1'b1,
		pc_mux: 1'b1, flag_mux: 1'b1,
		alu_func: alu_pass_b, bbus_mux: sel_d_bus
	};

endpackage

/* src/isa_pkg.sv */
/* isa_pkg
   instruction set of the 8-bit accumulator core: opcode views, field codes,
   ALU functions, register selects, flag bits and decoded instruction form */
package isa_pkg;

	typedef enum logic [3:0] {
		alu_nul    = 4'b0000,	// function 0, reset value only
		alu_sub    = 4'b0001,	// a - b, used by cmp
		alu_pass_b = 4'b1000,	// c_bus = b_bus
		alu_pass_a = 4'b1001	// c_bus = acc
	} alu_op_t;

	typedef enum logic [2:0] {
		sel_acc   = 3'b000,
		sel_ax    = 3'b001,
		sel_bx    = 3'b010,
		sel_pc_lo = 3'b011,
		sel_flag  = 3'b100,
		sel_p     = 3'b101,	// port register
		sel_d_bus = 3'b110,	// external data bus
		sel_imm   = 3'b111	// operand follows in code memory
	} reg_sel_t;

	typedef struct packed {
		logic carry;	// bit 2
		logic positive;	// bit 1
		logic zero;	// bit 0
	} flag_t;

	// one opcode byte, read either as alu op or as move/branch op
	typedef union packed {
		struct packed {
			logic     top;	// clear for alu group
			alu_op_t  func;	// also the branch condition
			reg_sel_t src;
		} alu;
		struct packed {
			logic [1:0] major;	// instruction group
			logic [2:0] dest;	// destination or condition low bits
			reg_sel_t   src;
		} mv;
	} opcode_u;

	localparam logic [1:0] maj_alu = 2'b00;	// alu group, reg or imm
	localparam logic [1:0] maj_ldi = 2'b10;	// with src imm
	localparam logic [4:0] pfx_cmp = 5'b01000;
	localparam logic [4:0] pfx_ld  = 5'b10001;
	localparam logic [4:0] pfx_st  = 5'b10010;

	// branch condition codes, bits 6:3
	localparam logic [3:0] cond_je  = 4'b0011;
	localparam logic [3:0] cond_jne = 4'b0100;
	localparam logic [3:0] cond_jp  = 4'b0101;
	localparam logic [3:0] cond_jn  = 4'b0110;
	localparam logic [3:0] cond_jc  = 4'b0111;
	localparam logic [3:0] cond_jnc = 4'b1000;
	localparam logic [3:0] cond_jmp = 4'b1001;

	typedef enum logic [3:0] {
		alu_reg, cmp_reg, ld_reg, st_reg,	// 2 cycles
		alu_imm, cmp_imm, ldi,	// 3 cycles
		branch,	// 4 cycles
		unsupported	// runs as nop
	} iclass_t;

	typedef struct packed {
		iclass_t  iclass;
		alu_op_t  alu_op;	// bits 6:3 as given
		reg_sel_t src_sel;
		reg_sel_t dest_sel;	// bits 5:3
		logic     taken;	// branch condition met
	} decoded_t;

endpackage

/* src/opcode_decoder.sv */
/* opcode_decoder
   classifies the latched opcode, pulls out its fields and resolves the
   branch condition against the flags */
module opcode_decoder
	import isa_pkg::*;
#(
	parameter int op_width = 8
) (
	input  opcode_u  reg_opl,
	input  flag_t    reg_flag,
	output decoded_t decoded
);

	logic [op_width-1:0] op_raw;	// raw opcode byte
	logic [4:0]          pfx;	// class prefix, bits 7:3
	logic [3:0]          cond;	// branch condition code
	logic                src_imm;	// operand comes from code memory

	assign op_raw  = reg_opl;
	assign pfx     = {reg_opl.mv.major, reg_opl.mv.dest};
	assign cond    = reg_opl.alu.func;
	assign src_imm = (reg_opl.alu.src == sel_imm);

	always_comb begin
		if (reg_opl.mv.major == maj_alu)	// alu, reg or imm
			decoded.iclass = src_imm ? alu_imm : alu_reg;
		else if (pfx == pfx_cmp)
			decoded.iclass = src_imm ? cmp_imm : cmp_reg;
		else if (pfx == pfx_ld && !src_imm)
			decoded.iclass = ld_reg;
		else if (pfx == pfx_st && !src_imm)
			decoded.iclass = st_reg;
		else if (reg_opl.mv.major == maj_ldi && src_imm)
			decoded.iclass = ldi;
		else if (op_raw[op_width-1] && reg_opl.alu.src == sel_acc)	// jumps, src 000
			decoded.iclass = branch;
		else
			decoded.iclass = unsupported;	// stack, ldm/stm and the rest
	end

	always_comb begin
		case (cond)
			cond_je:  decoded.taken = reg_flag.zero;
			cond_jne: decoded.taken = ~reg_flag.zero;
			cond_jp:  decoded.taken = reg_flag.positive;
			cond_jn:  decoded.taken = ~reg_flag.positive;
			cond_jc:  decoded.taken = reg_flag.carry;
			cond_jnc: decoded.taken = ~reg_flag.carry;
			cond_jmp: decoded.taken = 1'b1;	// unconditional
			default:  decoded.taken = 1'b0;	// undefined code never jumps
		endcase
	end

	assign decoded.alu_op   = reg_opl.alu.func;	// bits 6:3 straight through
	assign decoded.src_sel  = reg_opl.alu.src;
	assign decoded.dest_sel = reg_sel_t'(reg_opl.mv.dest);	// ldi destination

endmodule

/* src/popcorn_sequencer.sv */
/* popcorn_sequencer
   control sequencer top: opcode decoder, step FSM and control word encoder */
module popcorn_sequencer
	import isa_pkg::*;
	import ctrl_pkg::*;
#(
	parameter int op_width = 8
) (
	input  logic       sys_clk,
	input  logic       sys_rst,
	input  opcode_u    reg_opl,
	input  flag_t      reg_flag,
	output seq_state_t seq_state,
	output ctrl_word_t ctrl
);

	decoded_t decoded;	// class, fields and branch result

	opcode_decoder #(.op_width(op_width)) decoder_i (
		.reg_opl  (reg_opl),
		.reg_flag (reg_flag),
		.decoded  (decoded)
	);

	seq_fsm fsm_i (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.decoded   (decoded),
		.seq_state (seq_state)
	);

	ctrl_encoder #(.op_width(op_width)) encoder_i (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.seq_state (seq_state),
		.decoded   (decoded),
		.ctrl      (ctrl)
	);

endmodule

/* src/seq_fsm.sv */
/* seq_fsm
   one-hot step register, s0 fetch through s3 branch operand */
module seq_fsm
	import isa_pkg::*;
	import ctrl_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst,
	input  decoded_t   decoded,
	output seq_state_t seq_state
);

	seq_state_t state_nxt;
	logic       two_cycle;	// done after s1
	logic       is_branch;

	assign two_cycle = (decoded.iclass == alu_reg) || (decoded.iclass == cmp_reg) ||
		(decoded.iclass == ld_reg) || (decoded.iclass == st_reg) ||
		(decoded.iclass == unsupported);
	assign is_branch = (decoded.iclass == branch);

	always_comb begin
		case (seq_state)
			s0:      state_nxt = s1;	// opcode now latched
			s1:      state_nxt = two_cycle ? s0 : s2;
			s2:      state_nxt = is_branch ? s3 : s0;	// high byte for jumps
			s3:      state_nxt = s0;
			default: state_nxt = s0;	// s4, s5 and illegal codes
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst) begin
		if (!sys_rst)
			seq_state <= s0;
		else
			seq_state <= state_nxt;
	end

endmodule
